// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_mul_top
DUT_TOP    = mul_top
FILELIST   = list.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== booth_pp_gen.sv ====
`default_nettype none

module booth_pp_gen (
	input  mul_pkg::operand_t multiplicand,
	input  mul_pkg::operand_t multiplier,
	input  logic              a_signed,
	input  logic              b_signed,
	output mul_pkg::row_t     pp_rows [mul_pkg::PP_NUM],
	output mul_pkg::row_t     neg_row
);

	localparam int EXT_PAD = mul_pkg::EXT_W - mul_pkg::XLEN;
	localparam int ROW_PAD = mul_pkg::PROD_W - mul_pkg::EXT_W - 1;

	mul_pkg::ext_t            a_ext;
	mul_pkg::ext_t            b_ext;
	logic [mul_pkg::EXT_W:0]  b_win;  // multiplier with the implicit zero below bit 0.
	logic [mul_pkg::PP_NUM-1:0] neg;

	assign a_ext = {{EXT_PAD{a_signed & multiplicand[mul_pkg::XLEN-1]}}, multiplicand};
	assign b_ext = {{EXT_PAD{b_signed & multiplier[mul_pkg::XLEN-1]}}, multiplier};
	assign b_win = {b_ext, 1'b0};

	for (genvar i = 0; i < mul_pkg::PP_NUM; i++) begin : g_digit
		logic [2:0]              win;
		logic                    one;
		logic                    two;
		logic [mul_pkg::EXT_W:0] sel;
		logic [mul_pkg::EXT_W:0] val;
		mul_pkg::row_t           row_ext;

		assign win = b_win[2*i +: 3];

		// 001/010 give 1x, 011/100 give 2x, 111 and 000 give zero.
		assign one = win[1] ^ win[0];
		assign two = (win == 3'b011) || (win == 3'b100);
		assign neg[i] = win[2] & ~(win[1] & win[0]);

		always_comb begin
			if (one) begin
				sel = {a_ext[mul_pkg::EXT_W-1], a_ext};
			end else if (two) begin
				sel = {a_ext, 1'b0};
			end else begin
				sel = '0;
			end
		end

		assign val = neg[i] ? ~sel : sel;  // the +1 goes to neg_row.
		assign row_ext = {{ROW_PAD{val[mul_pkg::EXT_W]}}, val};
		assign pp_rows[i] = row_ext << (2 * i);
	end

	always_comb begin
		neg_row = '0;
		for (int i = 0; i < mul_pkg::PP_NUM; i++) begin
			neg_row[2*i] = neg[i];
		end
	end

endmodule

`default_nettype wire

// ==== list.f ====
mul_pkg.sv
booth_pp_gen.sv
pp_switch.sv
wallace_column.sv
wallace_array.sv
mul_top.sv
tb_mul_top.sv

// ==== mul_pkg.sv ====
`default_nettype none

package mul_pkg;

	localparam int XLEN     = 16;  // operand width.
	localparam int EXT_W    = 18;  // operand after sign or zero extension.
	localparam int PP_NUM   = 9;   // radix-4 booth digits.
	localparam int ROWS     = 10;  // booth rows plus the negation row.
	localparam int PROD_W   = 36;  // row width, also the column count.
	localparam int WT_CARRY = 7;   // carries passed to the next column.
	localparam int RES_W    = 32;

	typedef logic [XLEN-1:0]     operand_t;
	typedef logic [EXT_W-1:0]    ext_t;
	typedef logic [PROD_W-1:0]   row_t;

	// one bit from each row at the same weight, negation row in bit 0.
	typedef logic [ROWS-1:0]     column_t;

	typedef logic [WT_CARRY-1:0] lateral_t;
	typedef logic [RES_W-1:0]    result_t;

endpackage

`default_nettype wire

// ==== mul_top.sv ====
`default_nettype none

module mul_top (
	input  logic               clock,
	input  logic               reset,
	input  logic               in_valid,
	input  mul_pkg::operand_t  multiplicand,
	input  mul_pkg::operand_t  multiplier,
	input  logic               a_signed,
	input  logic               b_signed,
	output logic               out_valid,
	output mul_pkg::result_t   result
);

	logic                        s1_valid;
	mul_pkg::operand_t           s1_a;
	mul_pkg::operand_t           s1_b;
	logic                        s1_a_signed;
	logic                        s1_b_signed;

	mul_pkg::row_t               pp_rows [mul_pkg::PP_NUM];
	mul_pkg::row_t               neg_row;
	mul_pkg::column_t            columns [mul_pkg::PROD_W];
	logic [mul_pkg::PROD_W-1:0]  tree_sum;
	logic [mul_pkg::PROD_W-1:0]  tree_carry;

	logic                        s2_valid;
	logic [mul_pkg::PROD_W-1:0]  s2_sum;
	logic [mul_pkg::PROD_W-1:0]  s2_carry;
	logic [mul_pkg::PROD_W-1:0]  final_sum;

	always_ff @(posedge clock) begin
		if (reset) begin
			s1_valid  <= 1'b0;
			s2_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			s1_valid  <= in_valid;
			s2_valid  <= s1_valid;
			out_valid <= s2_valid;
		end
	end

	always_ff @(posedge clock) begin
		s1_a        <= multiplicand;
		s1_b        <= multiplier;
		s1_a_signed <= a_signed;
		s1_b_signed <= b_signed;
	end

	booth_pp_gen u_booth (
		.multiplicand (s1_a),
		.multiplier   (s1_b),
		.a_signed     (s1_a_signed),
		.b_signed     (s1_b_signed),
		.pp_rows      (pp_rows),
		.neg_row      (neg_row)
	);

	pp_switch u_switch (
		.pp_rows (pp_rows),
		.neg_row (neg_row),
		.columns (columns)
	);

	wallace_array u_tree (
		.columns    (columns),
		.tree_sum   (tree_sum),
		.tree_carry (tree_carry)
	);

	always_ff @(posedge clock) begin
		s2_sum   <= tree_sum;
		s2_carry <= tree_carry;
	end

	// carry bits weigh one column more than the sum bits.
	assign final_sum = s2_sum + {s2_carry[mul_pkg::PROD_W-2:0], 1'b0};

	always_ff @(posedge clock) begin
		result <= final_sum[mul_pkg::RES_W-1:0];
	end

	// three edges from in_valid to out_valid, while reset stays low.
	a_valid_latency: assert property (@(posedge clock)
		(!reset && !$past(reset) && !$past(reset, 2) && !$past(reset, 3))
		|-> (out_valid == $past(in_valid, 3)));

	a_reset_clears: assert property (@(posedge clock) reset |=> !out_valid);

	a_tree_known: assert property (@(posedge clock) disable iff (reset)
		s1_valid |-> !$isunknown({tree_sum, tree_carry}));

endmodule

`default_nettype wire

// ==== pp_switch.sv ====
`default_nettype none

module pp_switch (
	input  mul_pkg::row_t    pp_rows [mul_pkg::PP_NUM],
	input  mul_pkg::row_t    neg_row,
	output mul_pkg::column_t columns [mul_pkg::PROD_W]
);

	// every column gets the same ten inputs, so every tree column can be
	// the same adder arrangement.
	always_comb begin
		for (int j = 0; j < mul_pkg::PROD_W; j++) begin
			columns[j][0] = neg_row[j];
			for (int r = 0; r < mul_pkg::PP_NUM; r++) begin
				columns[j][r+1] = pp_rows[r][j];
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_mul_top.sv ====
`default_nettype none

module tb_mul_top;

	logic               clock;
	logic               reset;
	logic               in_valid;
	mul_pkg::operand_t  multiplicand;
	mul_pkg::operand_t  multiplier;
	logic               a_signed;
	logic               b_signed;
	logic               out_valid;
	mul_pkg::result_t   result;

	int                 cycle;
	int                 errors;
	int                 checks;
	int                 tests;
	int                 test_errors;
	string              cur_test;

	// expected results and the cycle in which each must show up.
	mul_pkg::result_t   exp_q [$];
	int                 exp_cycle_q [$];
	mul_pkg::result_t   exp_val;
	int                 exp_cyc;

	mul_pkg::operand_t  corners [5] = '{16'h0000, 16'h0001, 16'hffff, 16'h8000, 16'h7fff};

	mul_top i_dut (
		.clock        (clock),
		.reset        (reset),
		.in_valid     (in_valid),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.a_signed     (a_signed),
		.b_signed     (b_signed),
		.out_valid    (out_valid),
		.result       (result)
	);

	always #20 clock = ~clock;

	always @(posedge clock) begin
		cycle <= cycle + 1;  // edge count, stable by the time inputs change.
	end

	// extend by the flags, multiply wide, keep the low word.
	function automatic mul_pkg::result_t model(
		input mul_pkg::operand_t a,
		input mul_pkg::operand_t b,
		input logic              as,
		input logic              bs
	);
		logic [63:0] ax;
		logic [63:0] bx;
		logic [63:0] p;
		ax = as ? {{48{a[15]}}, a} : {48'd0, a};
		bx = bs ? {{48{b[15]}}, b} : {48'd0, b};
		p = ax * bx;
		return p[31:0];
	endfunction

	task automatic check(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAIL %s %s: expected 0x%0h, actual 0x%0h",
				cur_test, what, expected, actual);
		end
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#2;
	endtask

	task automatic issue(input mul_pkg::operand_t a, input mul_pkg::operand_t b,
			input logic as, input logic bs);
		in_valid = 1'b1;
		multiplicand = a;
		multiplier = b;
		a_signed = as;
		b_signed = bs;
		exp_q.push_back(model(a, b, as, bs));
		exp_cycle_q.push_back(cycle + 3);  // the drive edge plus two.
	endtask

	task automatic issue_random();
		issue(16'($urandom), 16'($urandom), 1'($urandom), 1'($urandom));
	endtask

	task automatic go_idle();
		in_valid = 1'b0;
		multiplicand = 16'($urandom);  // data should not matter while idle.
		multiplier = 16'($urandom);
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < limit) begin
			@(posedge clock);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout in %s: %0d results never came out after %0d cycles",
				cur_test, exp_q.size(), limit);
			errors++;
			exp_q.delete();
			exp_cycle_q.delete();
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("test %-8s done, %0d errors", cur_test, errors - test_errors);
	endtask

	// pops one expected entry per out_valid, also notices missing ones.
	always @(negedge clock) begin
		if (!reset) begin
			if (out_valid) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("error in %s: out_valid high with no operation outstanding",
						cur_test);
				end else begin
					exp_val = exp_q.pop_front();
					exp_cyc = exp_cycle_q.pop_front();
					check("result", exp_val, result);
					check("out cycle", 32'(exp_cyc), 32'(cycle));
				end
			end else if (exp_cycle_q.size() != 0 && exp_cycle_q[0] <= cycle) begin
				errors++;
				$display("error in %s: out_valid missing in cycle %0d",
					cur_test, exp_cycle_q[0]);
				exp_val = exp_q.pop_front();
				exp_cyc = exp_cycle_q.pop_front();
			end
		end
	end

	task automatic test_reset();
		start_test("reset");
		for (int i = 0; i < 2; i++) begin
			next_cycle();
			check("out_valid in reset", 32'd0, 32'(out_valid));
		end
		reset = 1'b0;
		for (int i = 0; i < 5; i++) begin
			next_cycle();
			check("out_valid idle", 32'd0, 32'(out_valid));
		end
		end_test();
	endtask

	task automatic test_corners();
		start_test("corners");
		for (int m = 0; m < 4; m++) begin
			for (int i = 0; i < 5; i++) begin
				for (int j = 0; j < 5; j++) begin
					next_cycle();
					issue(corners[i], corners[j], m[1], m[0]);
					next_cycle();
					go_idle();
					wait_drain(10);
				end
			end
		end
		end_test();
	endtask

	task automatic test_random();
		start_test("random");
		for (int i = 0; i < 200; i++) begin
			next_cycle();
			issue_random();
			next_cycle();
			go_idle();
			wait_drain(10);
		end
		end_test();
	endtask

	// consecutive issues, so the cycle check also proves order and spacing.
	task automatic test_stream();
		start_test("stream");
		for (int i = 0; i < 30; i++) begin
			next_cycle();
			issue_random();
		end
		next_cycle();
		go_idle();
		wait_drain(10);
		end_test();
	endtask

	task automatic test_bubbles();
		start_test("bubbles");
		for (int i = 0; i < 60; i++) begin
			next_cycle();
			if (1'($urandom)) begin
				issue_random();
			end else begin
				go_idle();
			end
		end
		next_cycle();
		go_idle();
		wait_drain(10);
		end_test();
	endtask

	initial begin
		void'($urandom(64));
		clock = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		multiplicand = '0;
		multiplier = '0;
		a_signed = 1'b0;
		b_signed = 1'b0;
		cycle = 0;
		errors = 0;
		checks = 0;
		tests = 0;
		test_errors = 0;
		cur_test = "init";

		test_reset();
		test_corners();
		test_random();
		test_stream();
		test_bubbles();

		// a few quiet cycles so a stray out_valid would still be caught.
		repeat (5) next_cycle();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== wallace_array.sv ====
`default_nettype none

module wallace_array (
	input  mul_pkg::column_t         columns [mul_pkg::PROD_W],
	output logic [mul_pkg::PROD_W-1:0] tree_sum,
	output logic [mul_pkg::PROD_W-1:0] tree_carry
);

	localparam int LAST = mul_pkg::PROD_W - 1;

	mul_pkg::lateral_t lat [mul_pkg::PROD_W];  // carries into column k.

	assign lat[0] = '0;

	for (genvar k = 0; k < mul_pkg::PROD_W; k++) begin : g_col
		if (k < LAST) begin : g_mid
			wallace_column u_column (
				.bits      (columns[k]),
				.carry_in  (lat[k]),
				.carry_out (lat[k+1]),
				.sum       (tree_sum[k]),
				.carry     (tree_carry[k])
			);
		end else begin : g_top
			// carries out of the top column are beyond the product width.
			wallace_column u_column (
				.bits      (columns[k]),
				.carry_in  (lat[k]),
				.carry_out (),
				.sum       (tree_sum[k]),
				.carry     (tree_carry[k])
			);
		end
	end

endmodule

`default_nettype wire

// ==== wallace_column.sv ====
`default_nettype none

module wallace_column (
	input  mul_pkg::column_t bits,
	input  mul_pkg::lateral_t carry_in,
	output mul_pkg::lateral_t carry_out,
	output logic             sum,
	output logic             carry
);

	logic [2:0] l1_sum;
	logic [1:0] l2_sum;
	logic       l3_sum;
	logic       l4_sum;

	// full adder, returns {carry, sum}.
	function automatic logic [1:0] fa(input logic x, input logic y, input logic z);
		return {(x & y) | (x & z) | (y & z), x ^ y ^ z};
	endfunction

	// layer 1, bits 0 to 8; bit 9 waits for layer 2.
	for (genvar i = 0; i < 3; i++) begin : g_l1
		assign {carry_out[i], l1_sum[i]} = fa(bits[3*i], bits[3*i+1], bits[3*i+2]);
	end

	// layer 2 takes the three layer-1 carries of the column below.
	assign {carry_out[3], l2_sum[0]} = fa(l1_sum[0], l1_sum[1], carry_in[0]);
	assign {carry_out[4], l2_sum[1]} = fa(bits[9], carry_in[1], carry_in[2]);

	assign {carry_out[5], l3_sum} = fa(l2_sum[0], carry_in[3], carry_in[4]);  // layer 3.

	assign {carry_out[6], l4_sum} = fa(l3_sum, l2_sum[1], carry_in[5]);  // layer 4.

	// last adder, l1_sum[2] has been waiting since layer 1.
	assign {carry, sum} = fa(l4_sum, l1_sum[2], carry_in[6]);

endmodule

`default_nettype wire
